/* compile.f */
hw/picoIoPkg.sv
hw/picoBusIf.sv
hw/picoPort.sv
hw/panelPorts.sv
hw/boardRamPorts.sv
hw/linkPorts.sv
hw/picoIoTop.sv
tb/picoIo_asserts.sv
tb/picoIoTb.sv

/* tb/picoIoTb.sv */
// directed testbench for picoIoTop, run as top module picoIoTb with the files of compile.f
`timescale 1ns/1ps

module picoIoTb import picoIoPkg::*; ();

  localparam int rxHoldCycles   = 10;    // defaults of picoIoTop
  localparam int txHoldCycles   = 2;
  localparam int watchdogCycles = 2000;  // tests need about 500 cycles, 4x margin

  logic        clk, arstN;
  portAddrT    portId;
  byteT        outPort, inPort, rxData, txData;
  logic        writeStrobe, interruptAck, intRequest, interrupt;
  btnT         btns;
  logic [15:0] sw, leds;
  digitT       dig3, dig2, dig1, dig0;
  dpT          dp;
  logic        connEstablished, usWrEn, themWrEn, rxReady, txSend;
  cellT        usRdVal, themRdVal, usWrVal, themWrVal;
  boardAddrT   cursor, usRdAddr, usWrAddr, themRdAddr, themWrAddr;

  integer seed = 15748;
  int     errCount = 0;
  int     errAtStart;
  int     testCount = 0;
  int     failedTests = 0;
  string  curTest;

  picoIoTop DUT (.*);  // default hold parameters

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // watchdog, ends a hung run
  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdogCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // bus tasks and checks
  //////////////////////////////////////////////////////////////////////
  task automatic ioWrite(input portAddrT addr, input byteT data);
    @(posedge clk);
    portId      <= addr;
    outPort     <= data;
    writeStrobe <= 1'b1;
    @(posedge clk);          // register loads here
    writeStrobe <= 1'b0;
  endtask

  // inPort holds the value one edge after the address is sampled
  task automatic ioRead(input portAddrT addr, output byteT data);
    @(posedge clk);
    portId <= addr;
    @(posedge clk);
    @(negedge clk);
    data = inPort;
  endtask

  task automatic checkByte(input string what, input byteT exp, input byteT act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected 0x%02h, actual 0x%02h", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic checkCell(input string what, input cellT exp, input cellT act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0d, actual %0d", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic checkBit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %b, actual %b", curTest, what, exp, act);
      errCount++;
    end
  endtask

  task automatic startTest(input string name);
    curTest    = name;
    errAtStart = errCount;
    testCount++;
  endtask

  task automatic endTest();
    if (errCount == errAtStart) begin
      $display("test %s: ok", curTest);
    end else begin
      $display("test %s: %0d errors", curTest, errCount - errAtStart);
      failedTests++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////
  task automatic testReset();
    byteT rd;
    startTest("reset");
    @(negedge clk);
    checkBit("interrupt", 1'b0, interrupt);
    checkBit("txSend", 1'b0, txSend);
    checkBit("usWrEn", 1'b0, usWrEn);
    checkBit("themWrEn", 1'b0, themWrEn);
    ioRead(paLedsLo, rd);
    checkByte("leds lo", 8'h00, rd);
    ioRead(paRamSel, rd);
    checkByte("bank", 8'h00, rd);
    ioRead(8'h1C, rd);       // unmapped
    checkByte("unmapped", 8'h00, rd);
    endTest();
  endtask

  task automatic testPanel();
    byteT lo, hi, d3, d2, d1, d0, p, b, s, rd;
    startTest("panel");
    lo = $random(seed);
    hi = $random(seed);
    d3 = $random(seed);
    d2 = $random(seed);
    d1 = $random(seed);
    d0 = $random(seed);
    p  = $random(seed);
    ioWrite(paLedsLo, lo);
    ioWrite(paLedsHi, hi);
    ioWrite(paDig3, d3);
    ioWrite(paDig2, d2);
    ioWrite(paDig1, d1);
    ioWrite(paDig0, d0);
    ioWrite(paDp, p);
    @(negedge clk);
    checkByte("leds lo", lo, leds[7:0]);
    checkByte("leds hi", hi, leds[15:8]);
    checkByte("dig3", {3'b000, d3[4:0]}, {3'b000, dig3});  // digits keep 5 bits
    checkByte("dig2", {3'b000, d2[4:0]}, {3'b000, dig2});
    checkByte("dig1", {3'b000, d1[4:0]}, {3'b000, dig1});
    checkByte("dig0", {3'b000, d0[4:0]}, {3'b000, dig0});
    checkByte("dp", {4'h0, p[3:0]}, {4'h0, dp});
    ioRead(paLedsLo, rd);
    checkByte("leds lo rd", lo, rd);
    ioRead(paLedsHi, rd);
    checkByte("leds hi rd", hi, rd);
    ioRead(paDig3, rd);
    checkByte("dig3 rd", {3'b000, d3[4:0]}, rd);
    ioRead(paDig2, rd);
    checkByte("dig2 rd", {3'b000, d2[4:0]}, rd);
    ioRead(paDig1, rd);
    checkByte("dig1 rd", {3'b000, d1[4:0]}, rd);
    ioRead(paDig0, rd);
    checkByte("dig0 rd", {3'b000, d0[4:0]}, rd);
    ioRead(paDp, rd);
    checkByte("dp rd", {4'h0, p[3:0]}, rd);
    b = $random(seed);
    s = $random(seed);
    @(posedge clk);
    btns <= b[4:0];
    sw   <= {s, ~s};
    ioRead(paBtns, rd);
    checkByte("btns", {3'b000, b[4:0]}, rd);
    ioRead(paBtnsAlt, rd);
    checkByte("btns alt", {3'b000, b[4:0]}, rd);
    ioRead(paSwLo, rd);
    checkByte("sw lo", ~s, rd);
    ioRead(paSwHi, rd);
    checkByte("sw hi", s, rd);
    endTest();
  endtask

  task automatic testRam();
    byteT a1, a2, v1, b1, b2, v2, rd;
    startTest("ram ports");
    a1 = $random(seed);
    a2 = $random(seed);
    v1 = $random(seed);
    b1 = $random(seed);
    b2 = $random(seed);
    v2 = $random(seed);
    ioWrite(paRamSel, {7'b0, bankUs});
    ioWrite(paCursor, a1);
    ioWrite(paRamWrAddr, a2);
    ioWrite(paRamWrVal, v1);
    @(negedge clk);
    checkByte("cursor", a1, cursor);
    checkByte("usRdAddr", a1, usRdAddr);
    checkByte("usWrAddr", a2, usWrAddr);
    checkCell("usWrVal", v1[1:0], usWrVal);
    checkBit("usWrEn", 1'b1, usWrEn);
    checkBit("themWrEn", 1'b0, themWrEn);
    ioRead(paRamWrAddr, rd);
    checkByte("us wr addr rd", a2, rd);
    // same writes now land on the them bank
    ioWrite(paRamSel, {7'b0, bankThem});
    ioWrite(paCursor, b1);
    ioWrite(paRamWrAddr, b2);
    ioWrite(paRamWrVal, v2);
    @(negedge clk);
    checkByte("cursor them", b1, cursor);
    checkByte("themRdAddr", b1, themRdAddr);
    checkByte("themWrAddr", b2, themWrAddr);
    checkCell("themWrVal", v2[1:0], themWrVal);
    checkBit("themWrEn", 1'b1, themWrEn);
    checkBit("usWrEn", 1'b0, usWrEn);     // cleared by the cursor write
    checkByte("usRdAddr kept", a1, usRdAddr);
    checkByte("usWrAddr kept", a2, usWrAddr);
    checkCell("usWrVal kept", v1[1:0], usWrVal);
    ioRead(paCursor, rd);
    checkByte("them cursor rd", b1, rd);
    ioRead(paRamWrVal, rd);
    checkByte("them wr val rd", {6'b0, v2[1:0]}, rd);
    @(posedge clk);
    themRdVal <= 2'd3;
    ioRead(paRamRdVal, rd);
    checkByte("them rd val", 8'h03, rd);
    ioWrite(paCursor, b1);
    @(negedge clk);
    checkBit("themWrEn clr", 1'b0, themWrEn);
    checkBit("usWrEn clr", 1'b0, usWrEn);
    ioWrite(paRamSel, {7'b0, bankUs});
    endTest();
  endtask

  task automatic testValid();
    byteT rd;
    startTest("valid flag");
    ioRead(paValidFlag, rd);
    checkByte("empty", flagValid, rd);
    ioWrite(paOob, oobMark);
    ioRead(paValidFlag, rd);
    checkByte("oob", flagInvalid, rd);
    ioWrite(paOob, 8'h23);
    usRdVal <= 2'd2;         // occupied cells under the ship
    repeat (4) @(posedge clk);
    ioRead(paValidFlag, rd);
    checkByte("occupied", flagInvalid, rd);
    @(posedge clk);
    usRdVal <= 2'd0;
    ioRead(paOob, rd);       // leaving the flag port clears the sum
    checkByte("oob rd", 8'h23, rd);
    ioRead(paValidFlag, rd);
    checkByte("cleared", flagValid, rd);
    endTest();
  endtask

  task automatic testLink();
    byteT r, t, rd;
    int   highCnt;
    startTest("link");
    r = $random(seed);
    @(posedge clk);
    rxData  <= r;
    rxReady <= 1'b1;
    @(posedge clk);
    rxReady <= 1'b0;
    ioRead(paRxData, rd);
    checkByte("rx byte", r, rd);
    ioRead(paConnEst, rd);
    checkBit("rx ready set", 1'b1, rd[6]);
    repeat (rxHoldCycles + 2) @(posedge clk);
    ioRead(paConnEst, rd);
    checkBit("rx ready clr", 1'b0, rd[6]);
    @(posedge clk);
    connEstablished <= 1'b1;
    ioRead(paConnEst, rd);
    checkByte("conn est", 8'h80, rd);
    t = $random(seed);
    ioWrite(paTxData, t);
    highCnt = 0;
    @(negedge clk);
    while (txSend && highCnt < 20) begin
      highCnt++;
      @(negedge clk);
    end
    checkByte("tx high cycles", byteT'(txHoldCycles), byteT'(highCnt));
    checkByte("txData", t, txData);
    ioRead(paTxData, rd);
    checkByte("tx rd", t, rd);
    endTest();
  endtask

  task automatic testIrq();
    startTest("interrupt");
    @(posedge clk);
    intRequest <= 1'b1;
    @(posedge clk);
    intRequest <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    checkBit("held", 1'b1, interrupt);
    @(posedge clk);
    interruptAck <= 1'b1;
    @(posedge clk);
    interruptAck <= 1'b0;
    @(negedge clk);
    checkBit("acked", 1'b0, interrupt);
    @(posedge clk);
    intRequest   <= 1'b1;    // ack has priority
    interruptAck <= 1'b1;
    @(posedge clk);
    intRequest   <= 1'b0;
    interruptAck <= 1'b0;
    repeat (2) @(negedge clk);
    checkBit("req with ack", 1'b0, interrupt);
    endTest();
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    arstN           = 1'b0;
    portId          = '0;
    outPort         = '0;
    writeStrobe     = 1'b0;
    interruptAck    = 1'b0;
    intRequest      = 1'b0;
    btns            = '0;
    sw              = '0;
    connEstablished = 1'b0;
    usRdVal         = '0;
    themRdVal       = '0;
    rxReady         = 1'b0;
    rxData          = '0;
    repeat (8) @(posedge clk);
    arstN <= 1'b1;
    testReset();
    testPanel();
    testRam();
    testValid();
    testLink();
    testIrq();
    $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
             testCount, failedTests, errCount, DUT.uAsserts.failCount);
    if (errCount == 0 && DUT.uAsserts.failCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb/picoIo_asserts.sv */
// concurrent assertions on picoIoTop outputs, bound into every picoIoTop instance
`timescale 1ns/1ps

module picoIo_asserts import picoIoPkg::*; #(
  parameter int txHoldCycles = 2
) (
  input logic     clk,
  input logic     arstN,
  input portAddrT portId,
  input logic     writeStrobe,
  input logic     interruptAck,
  input logic     interrupt,
  input logic     txSend,
  input logic     usWrEn,
  input logic     themWrEn
);

  logic txWr;           // write to the tx port at this edge
  int   failCount = 0;  // failed assertions so far

  assign txWr = writeStrobe && (portId == paTxData);

  // no write in the window means the send pulse must end
  txBounded: assert property (@(posedge clk) disable iff (!arstN)
    (txSend && !txWr) [*txHoldCycles] |=> !txSend)
    else begin
      failCount++;
      $error("txSend high longer than %0d cycles", txHoldCycles);
    end

  irqFall: assert property (@(posedge clk) disable iff (!arstN)
    $fell(interrupt) |-> $past(interruptAck))
    else begin
      failCount++;
      $error("interrupt fell without an acknowledge");
    end

  // first edge out of reset
  resetLow: assert property (@(posedge clk)
    $rose(arstN) |-> !interrupt && !txSend && !usWrEn && !themWrEn)
    else begin
      failCount++;
      $error("control outputs active after reset");
    end

endmodule

bind picoIoTop picoIo_asserts #(.txHoldCycles(txHoldCycles)) uAsserts (
  .clk, .arstN, .portId, .writeStrobe, .interruptAck,
  .interrupt, .txSend, .usWrEn, .themWrEn
);

/* hw/picoIoTop.sv */
// top level of the PicoBlaze I/O block, plain pins to the processor, panel, board RAM and radio
`timescale 1ns/1ps

module picoIoTop import picoIoPkg::*; #(
  parameter int rxHoldCycles = 10,
  parameter int txHoldCycles = 2
) (
  input  logic        clk,
  input  logic        arstN,

  // processor port bus
  input  portAddrT    portId,
  input  byteT        outPort,
  input  logic        writeStrobe,
  output byteT        inPort,
  input  logic        interruptAck,
  input  logic        intRequest,
  output logic        interrupt,

  // front panel
  input  btnT         btns,
  input  logic [15:0] sw,
  output logic [15:0] leds,
  output digitT       dig3,
  output digitT       dig2,
  output digitT       dig1,
  output digitT       dig0,
  output dpT          dp,

  // board RAM
  input  logic        connEstablished,
  input  cellT        usRdVal,
  input  cellT        themRdVal,
  output boardAddrT   cursor,
  output boardAddrT   usRdAddr,
  output boardAddrT   usWrAddr,
  output boardAddrT   themRdAddr,
  output boardAddrT   themWrAddr,
  output logic        usWrEn,
  output logic        themWrEn,
  output cellT        usWrVal,
  output cellT        themWrVal,

  // radio link
  input  logic        rxReady,
  input  byteT        rxData,
  output logic        txSend,
  output byteT        txData
);

  picoBusIf bus ();  // shared port bus

  picoPort uPort (
    .clk, .arstN, .portId, .outPort, .writeStrobe,
    .interruptAck, .intRequest,
    .bus      (bus.host),
    .inPort, .interrupt
  );

  panelPorts uPanel (
    .clk, .arstN, .btns, .sw,
    .bus      (bus.panel),
    .leds, .dig3, .dig2, .dig1, .dig0, .dp
  );

  boardRamPorts uRam (
    .clk, .arstN, .connEstablished, .usRdVal, .themRdVal,
    .bus      (bus.ram),
    .cursor, .usRdAddr, .usWrAddr, .themRdAddr, .themWrAddr,
    .usWrEn, .themWrEn, .usWrVal, .themWrVal
  );

  linkPorts #(
    .rxHoldCycles (rxHoldCycles),
    .txHoldCycles (txHoldCycles)
  ) uLink (
    .clk, .arstN, .rxReady, .rxData,
    .bus      (bus.link),
    .txSend, .txData
  );

endmodule

/* hw/linkPorts.sv */
// radio link ports: receive latch with stretched ready bit, transmit byte with stretched send pulse
`timescale 1ns/1ps

module linkPorts import picoIoPkg::*; #(
  parameter int rxHoldCycles = 10,  // ready bit length after the last rx pulse
  parameter int txHoldCycles = 2    // txSend length per write
) (
  input  logic clk,
  input  logic arstN,
  input  logic rxReady,   // one-cycle pulse from the radio
  input  byteT rxData,

  picoBusIf.link bus,

  output logic txSend,
  output byteT txData
);

  localparam int rxCntW = $clog2(rxHoldCycles + 1);
  localparam int txCntW = $clog2(txHoldCycles + 1);

  byteT              rxLatch;
  logic [rxCntW-1:0] rxCnt;      // nonzero while ready is stretched
  logic [txCntW-1:0] txCnt;      // nonzero while sending
  logic              rxHold;

  assign rxHold = (rxCnt != '0);
  assign txSend = (txCnt != '0);  // high from the write edge for txHoldCycles

  //////////////////////////////////////////////////////////////////////
  // receive
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rxLatch <= '0;
      rxCnt   <= '0;
    end else if (rxReady) begin
      rxLatch <= rxData;
      rxCnt   <= rxCntW'(rxHoldCycles);  // each pulse restarts the window
    end else if (rxHold) begin
      rxCnt <= rxCnt - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // transmit
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      txData <= '0;
      txCnt  <= '0;
    end else if (bus.writeStrobe && bus.portId == paTxData) begin
      txData <= bus.outPort;
      txCnt  <= txCntW'(txHoldCycles);   // new write restarts the count
    end else if (txSend) begin
      txCnt <= txCnt - 1'b1;
    end
  end

  // readback, ready bit joins connEstablished at paConnEst
  always_comb begin
    case (bus.portId)
      paConnEst: bus.linkRd = {1'b0, rxHold, 6'b0};
      paRxData:  bus.linkRd = rxLatch;
      paTxData:  bus.linkRd = txData;
      default:   bus.linkRd = '0;
    endcase
  end

endmodule

/* hw/boardRamPorts.sv */
// board RAM access ports: bank select, us/them addresses and values, cursor and placement valid flag
`timescale 1ns/1ps

module boardRamPorts import picoIoPkg::*; (
  input  logic      clk,
  input  logic      arstN,
  input  logic      connEstablished,  // radio link is up
  input  cellT      usRdVal,          // read data, own ships
  input  cellT      themRdVal,        // read data, guesses

  picoBusIf.ram     bus,

  output boardAddrT cursor,
  output boardAddrT usRdAddr,
  output boardAddrT usWrAddr,
  output boardAddrT themRdAddr,
  output boardAddrT themWrAddr,
  output logic      usWrEn,
  output logic      themWrEn,
  output cellT      usWrVal,
  output cellT      themWrVal
);

  logic       bankSel;    // bankUs or bankThem
  byteT       oobReg;     // oobMark when the ship runs off the board
  byteT       occAcc;     // occupancy seen since the last flag read
  logic       clrArmed;   // flag read seen, zero occAcc next edge
  logic [8:0] occSum;     // carry out flags saturation
  byteT       validFlag;
  boardAddrT  selRdAddr;
  boardAddrT  selWrAddr;
  cellT       selWrVal;
  cellT       selRdVal;

  // selected-bank views for readback
  assign selRdAddr = (bankSel == bankUs) ? usRdAddr  : themRdAddr;
  assign selWrAddr = (bankSel == bankUs) ? usWrAddr  : themWrAddr;
  assign selWrVal  = (bankSel == bankUs) ? usWrVal   : themWrVal;
  assign selRdVal  = (bankSel == bankUs) ? usRdVal   : themRdVal;

  //////////////////////////////////////////////////////////////////////
  // strobed writes
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bankSel    <= bankUs;
      oobReg     <= '0;
      cursor     <= '0;
      usRdAddr   <= '0;
      usWrAddr   <= '0;
      themRdAddr <= '0;
      themWrAddr <= '0;
      usWrEn     <= 1'b0;
      themWrEn   <= 1'b0;
      usWrVal    <= '0;
      themWrVal  <= '0;
    end else if (bus.writeStrobe) begin
      case (bus.portId)
        paRamSel: bankSel <= bus.outPort[0];
        paOob:    oobReg  <= bus.outPort;
        paCursor: begin
          cursor   <= bus.outPort;
          usWrEn   <= 1'b0;                 // cursor move means read mode
          themWrEn <= 1'b0;
          if (bankSel == bankThem) themRdAddr <= bus.outPort;
          else                     usRdAddr   <= bus.outPort;
        end
        paRamWrAddr: begin
          if (bankSel == bankThem) begin
            themWrAddr <= bus.outPort;
            themWrEn   <= 1'b1;             // held until next cursor write
          end else begin
            usWrAddr <= bus.outPort;
            usWrEn   <= 1'b1;
          end
        end
        paRamWrVal: begin
          if (bankSel == bankThem) themWrVal <= bus.outPort[1:0];
          else                     usWrVal   <= bus.outPort[1:0];
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // occupancy accumulator
  //////////////////////////////////////////////////////////////////////
  assign occSum = {1'b0, occAcc} + {7'b0, usRdVal};

  // sums usRdVal while the processor walks a ship, cleared after each flag read
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      occAcc   <= '0;
      clrArmed <= 1'b0;
    end else if (bus.portId == paValidFlag) begin
      clrArmed <= 1'b1;                     // hold value for this read
    end else if (clrArmed) begin
      occAcc   <= '0;
      clrArmed <= 1'b0;
    end else begin
      occAcc <= occSum[8] ? 8'hFF : occSum[7:0];  // saturate at 255
    end
  end

  // valid only when on the board and nothing occupied
  assign validFlag = ((oobReg != oobMark) && (occAcc == '0)) ? flagValid : flagInvalid;

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (bus.portId)
      paOob:       bus.ramRd = oobReg;
      paConnEst:   bus.ramRd = {connEstablished, 7'b0};  // bit 6 comes from link
      paCursor:    bus.ramRd = selRdAddr;
      paRamWrAddr: bus.ramRd = selWrAddr;
      paValidFlag: bus.ramRd = validFlag;
      paRamSel:    bus.ramRd = {7'b0, bankSel};
      paRamWrVal:  bus.ramRd = {6'b0, selWrVal};
      paRamRdVal:  bus.ramRd = {6'b0, selRdVal};
      default:     bus.ramRd = '0;
    endcase
  end

endmodule

/* hw/panelPorts.sv */
// front panel ports: LED bytes, four digits and decimal points, with button and switch readback
`timescale 1ns/1ps

module panelPorts import picoIoPkg::*; (
  input  logic        clk,
  input  logic        arstN,
  input  btnT         btns,   // debounced
  input  logic [15:0] sw,     // debounced

  picoBusIf.panel     bus,

  output logic [15:0] leds,
  output digitT       dig3,
  output digitT       dig2,
  output digitT       dig1,
  output digitT       dig0,
  output dpT          dp
);

  //////////////////////////////////////////////////////////////////////
  // strobed writes
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      leds <= '0;
      dig3 <= '0;
      dig2 <= '0;
      dig1 <= '0;
      dig0 <= '0;
      dp   <= '0;
    end else if (bus.writeStrobe) begin
      case (bus.portId)
        paLedsLo: leds[7:0]  <= bus.outPort;
        paLedsHi: leds[15:8] <= bus.outPort;
        paDig3:   dig3       <= bus.outPort[4:0];  // digit code is 5 bits
        paDig2:   dig2       <= bus.outPort[4:0];
        paDig1:   dig1       <= bus.outPort[4:0];
        paDig0:   dig0       <= bus.outPort[4:0];
        paDp:     dp         <= bus.outPort[3:0];  // lower four points only
        default:  ;                                // not a panel port
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////
  // inputs first, then each register at its own address
  always_comb begin
    case (bus.portId)
      paBtns:    bus.panelRd = {3'b000, btns};
      paBtnsAlt: bus.panelRd = {3'b000, btns};  // same buttons, alternate port
      paSwLo:    bus.panelRd = sw[7:0];
      paSwHi:    bus.panelRd = sw[15:8];
      paLedsLo:  bus.panelRd = leds[7:0];
      paLedsHi:  bus.panelRd = leds[15:8];
      paDig3:    bus.panelRd = {3'b000, dig3};
      paDig2:    bus.panelRd = {3'b000, dig2};
      paDig1:    bus.panelRd = {3'b000, dig1};
      paDig0:    bus.panelRd = {3'b000, dig0};
      paDp:      bus.panelRd = {4'b0000, dp};
      default:   bus.panelRd = '0;              // leave the OR to other groups
    endcase
  end

endmodule

/* hw/picoPort.sv */
// processor-facing side of the I/O block: drives the port bus, registers read data, holds the interrupt
`timescale 1ns/1ps

module picoPort import picoIoPkg::*; (
  input  logic     clk,
  input  logic     arstN,

  // PicoBlaze port pins
  input  portAddrT portId,
  input  byteT     outPort,
  input  logic     writeStrobe,
  input  logic     interruptAck,   // from the processor
  input  logic     intRequest,     // from the game logic

  picoBusIf.host   bus,

  output byteT     inPort,         // registered read data
  output logic     interrupt
);

  byteT rdMerge;  // OR of the group readbacks

  //////////////////////////////////////////////////////////////////////
  // bus drive
  //////////////////////////////////////////////////////////////////////
  assign bus.portId      = portId;
  assign bus.outPort     = outPort;
  assign bus.writeStrobe = writeStrobe;

  // groups return zero off their own ports, so OR is a mux
  assign rdMerge = bus.panelRd | bus.ramRd | bus.linkRd;

  // one cycle of read latency, read strobe not needed
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      inPort <= '0;
    end else begin
      inPort <= rdMerge;  // unmapped addresses read 0x00
    end
  end

  //////////////////////////////////////////////////////////////////////
  // closed-loop interrupt
  //////////////////////////////////////////////////////////////////////
  // set on request, held until the processor acknowledges
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      interrupt <= 1'b0;
    end else if (interruptAck) begin
      interrupt <= 1'b0;  // ack wins over a same-cycle request
    end else if (intRequest) begin
      interrupt <= 1'b1;
    end
  end

endmodule

/* hw/picoBusIf.sv */
// internal port bus: processor address, write data and strobe out, one readback byte per group
`timescale 1ns/1ps

interface picoBusIf import picoIoPkg::*; ();

  portAddrT portId;       // address from the processor
  byteT     outPort;      // write data
  logic     writeStrobe;  // qualifies outPort

  // combinational readbacks, zero when the address is not in the group
  byteT     panelRd;
  byteT     ramRd;
  byteT     linkRd;

  // processor side, drives the bus and merges readbacks
  modport host (
    output portId, outPort, writeStrobe,
    input  panelRd, ramRd, linkRd
  );

  // port groups, each owns one readback
  modport panel (
    input  portId, outPort, writeStrobe,
    output panelRd
  );

  modport ram (
    input  portId, outPort, writeStrobe,
    output ramRd
  );

  modport link (
    input  portId, outPort, writeStrobe,
    output linkRd
  );

endinterface

/* hw/picoIoPkg.sv */
// shared types, port map and flag codes for the PicoBlaze I/O block, imported by every module
package picoIoPkg;

  //////////////////////////////////////////////////////////////////////
  // widths that carry a meaning
  //////////////////////////////////////////////////////////////////////
  typedef logic [7:0] byteT;       // processor data byte
  typedef logic [7:0] portAddrT;   // port address from portId
  typedef logic [7:0] boardAddrT;  // board RAM cell address
  typedef logic [1:0] cellT;       // cell value: ship, hit, miss
  typedef logic [4:0] digitT;      // seven-segment digit code
  typedef logic [3:0] dpT;         // decimal points 3:0
  typedef logic [4:0] btnT;        // debounced buttons

  //////////////////////////////////////////////////////////////////////
  // port map, 0x00 - 0x1F
  //////////////////////////////////////////////////////////////////////
  // front panel
  localparam portAddrT paBtns      = 8'h00;  // (i) buttons
  localparam portAddrT paSwLo      = 8'h01;  // (i) switches 7:0
  localparam portAddrT paLedsLo    = 8'h02;  // (o) leds 7:0
  localparam portAddrT paDig3      = 8'h03;
  localparam portAddrT paDig2      = 8'h04;
  localparam portAddrT paDig1      = 8'h05;
  localparam portAddrT paDig0      = 8'h06;
  localparam portAddrT paDp        = 8'h07;  // (o) decimal points 3:0

  // board RAM access
  localparam portAddrT paOob       = 8'h08;  // (o) out-of-bounds marker
  localparam portAddrT paConnEst   = 8'h09;  // (i) bit7 link up, bit6 rx ready
  localparam portAddrT paCursor    = 8'h0A;  // (o) cursor and read address
  localparam portAddrT paRamWrAddr = 8'h0B;  // (o) write address, sets write enable
  localparam portAddrT paValidFlag = 8'h0C;  // (i) placement valid flag

  // extended ports
  localparam portAddrT paBtnsAlt   = 8'h10;  // (i) buttons, alternate address
  localparam portAddrT paSwHi      = 8'h11;  // (i) switches 15:8
  localparam portAddrT paLedsHi    = 8'h12;  // (o) leds 15:8
  localparam portAddrT paRamSel    = 8'h13;  // (o) bank select, bit 0
  localparam portAddrT paRamWrVal  = 8'h18;  // (o) cell write value
  localparam portAddrT paRxData    = 8'h19;  // (i) latched radio byte
  localparam portAddrT paTxData    = 8'h1E;  // (o) radio byte to send
  localparam portAddrT paRamRdVal  = 8'h1F;  // (i) selected bank read value

  //////////////////////////////////////////////////////////////////////
  // codes
  //////////////////////////////////////////////////////////////////////
  localparam byteT oobMark     = 8'hFF;  // cursor left the board
  localparam byteT flagValid   = 8'h01;
  localparam byteT flagInvalid = 8'h00;

  localparam logic bankUs   = 1'b0;  // own ships
  localparam logic bankThem = 1'b1;  // our guesses

endpackage
